/* hdc_bundler.f */
+incdir+src
src/hdc_pkg.sv
src/axil_regs.sv
src/item_vector_gen.sv
src/bundle_accum.sv
src/result_buffer.sv
src/hdc_bundler.sv
verif/tb_hdc_bundler.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bundler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/10ps \
    --top-module tb_hdc_bundler \
    -f hdc_bundler.f \
    -Mdir obj_dir

out=$(./obj_dir/Vtb_hdc_bundler)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* src/axil_regs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "hdc_settings.svh"

module axil_regs (
    input  wire logic       AXIS_ACLK,
    input  wire logic       S_AXI_ARESETN,
    input  wire logic [11:0] S_AXI_AWADDR,
    input  wire logic       S_AXI_AWVALID,
    output logic            S_AXI_AWREADY,
    input  wire logic [31:0] S_AXI_WDATA,
    input  wire logic [3:0] S_AXI_WSTRB,
    input  wire logic       S_AXI_WVALID,
    output logic            S_AXI_WREADY,
    output logic [1:0]      S_AXI_BRESP,
    output logic            S_AXI_BVALID,
    input  wire logic       S_AXI_BREADY,
    input  wire logic [11:0] S_AXI_ARADDR,
    input  wire logic       S_AXI_ARVALID,
    output logic            S_AXI_ARREADY,
    output logic [31:0]     S_AXI_RDATA,
    output logic [1:0]      S_AXI_RRESP,
    output logic            S_AXI_RVALID,
    input  wire logic       S_AXI_RREADY,
    input  wire logic       gen_done,
    output hdc_pkg::ctrl_t  ctrl
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_BRESP,
        ST_RFETCH,
        ST_RRESP
    } state_t;

    state_t      state;
    logic [11:0] awaddr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    logic [11:0] araddr_q;
    logic        wr_en;
    logic [11:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        ctrl_wr;
    logic        item_wr;
    logic [31:0] rd_word;

    // ============================================================
    // handshake outputs
    // ============================================================

    assign S_AXI_AWREADY = (state == ST_IDLE) || (state == ST_DATA);
    assign S_AXI_WREADY  = (state == ST_IDLE) || (state == ST_ADDR);
    // pending write beats any read
    assign S_AXI_ARREADY = (state == ST_IDLE) && !S_AXI_AWVALID && !S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == ST_BRESP);
    assign S_AXI_RVALID  = (state == ST_RRESP);
    assign S_AXI_BRESP   = 2'b00;
    assign S_AXI_RRESP   = 2'b00;

    // write lands when the second of address and data is taken
    assign wr_en = ((state == ST_IDLE) && S_AXI_AWVALID && S_AXI_WVALID)
                || ((state == ST_ADDR) && S_AXI_WVALID)
                || ((state == ST_DATA) && S_AXI_AWVALID);
    assign wr_addr = (state == ST_ADDR) ? awaddr_q : S_AXI_AWADDR;
    assign wr_data = (state == ST_DATA) ? wdata_q : S_AXI_WDATA;
    assign wr_strb = (state == ST_DATA) ? wstrb_q : S_AXI_WSTRB;
    assign ctrl_wr = wr_en && ({wr_addr[11:2], 2'b00} == `HDC_REG_CTRL);
    assign item_wr = wr_en && ({wr_addr[11:2], 2'b00} == `HDC_REG_ITEM);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state <= ST_BRESP;
                    end else if (S_AXI_AWVALID) begin
                        state <= ST_ADDR;
                    end else if (S_AXI_WVALID) begin
                        state <= ST_DATA;
                    end else if (S_AXI_ARVALID) begin
                        state <= ST_RFETCH;
                    end
                end
                ST_ADDR: begin
                    if (S_AXI_WVALID) begin
                        state <= ST_BRESP;
                    end
                end
                ST_DATA: begin
                    if (S_AXI_AWVALID) begin
                        state <= ST_BRESP;
                    end
                end
                ST_BRESP: begin
                    if (S_AXI_BREADY) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RFETCH: begin
                    state <= ST_RRESP;
                end
                ST_RRESP: begin
                    if (S_AXI_RREADY) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // held address, data and read word
    always_ff @(posedge AXIS_ACLK) begin
        if (S_AXI_AWVALID && S_AXI_AWREADY) begin
            awaddr_q <= S_AXI_AWADDR;
        end
        if (S_AXI_WVALID && S_AXI_WREADY) begin
            wdata_q <= S_AXI_WDATA;
            wstrb_q <= S_AXI_WSTRB;
        end
        if (S_AXI_ARVALID && S_AXI_ARREADY) begin
            araddr_q <= S_AXI_ARADDR;
        end
        if (state == ST_RFETCH) begin
            S_AXI_RDATA <= rd_word;
        end
    end

    // ============================================================
    // register file
    // ============================================================

    always_comb begin
        rd_word = '0;
        case ({araddr_q[11:2], 2'b00})
            `HDC_REG_CTRL: rd_word[1:0] = {ctrl.run, ctrl.gen};
            `HDC_REG_ITEM: rd_word[`HDC_IDX_W-1:0] = ctrl.item_sel;
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            ctrl <= '0;
        end else begin
            // a CTRL write on the same edge overrides gen_done
            if (ctrl_wr && wr_strb[0]) begin
                ctrl.run <= wr_data[1];
                ctrl.gen <= wr_data[0];
            end else if (gen_done) begin
                ctrl.gen <= 1'b0;
            end
            if (item_wr && wr_strb[0]) begin
                ctrl.item_sel[7:0] <= wr_data[7:0];
            end
            if (item_wr && wr_strb[1]) begin
                ctrl.item_sel[15:8] <= wr_data[15:8];
            end
        end
    end

endmodule

`default_nettype wire

/* src/bundle_accum.sv */
`timescale 1ns/10ps
`default_nettype none
`include "hdc_settings.svh"

module bundle_accum (
    input  wire logic           AXIS_ACLK,
    input  wire logic           S_AXI_ARESETN,
    input  wire hdc_pkg::ctrl_t ctrl,
    input  wire hdc_pkg::hv_t   tie_vec,
    input  wire hdc_pkg::hv_t   S_AXIS_TDATA,
    input  wire logic           S_AXIS_TVALID,
    input  wire logic           S_AXIS_TLAST,
    output logic                S_AXIS_TREADY,
    output hdc_pkg::hv_t        res_data,
    output logic                res_valid,
    input  wire logic           res_ready
);

    import hdc_pkg::*;

    cnt_t vote_q [`HDC_DIM];
    cnt_t beats_q;
    logic fin_q;
    logic accept;
    logic clr;

    // ============================================================
    // stream acceptance
    // ============================================================

    // stalled during generation and while a result waits
    assign S_AXIS_TREADY = ctrl.run && !ctrl.gen && !fin_q;
    assign accept        = S_AXIS_TVALID && S_AXIS_TREADY;
    assign res_valid     = fin_q;

    // cleared once the result is taken or when run drops
    assign clr = !ctrl.run || (fin_q && res_ready);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || clr) begin
            beats_q <= '0;
            fin_q   <= 1'b0;
        end else if (accept) begin
            beats_q <= beats_q + 1'b1;
            fin_q   <= S_AXIS_TLAST;
        end
    end

    // ============================================================
    // per-bit vote counters
    // ============================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || clr) begin
            for (int i = 0; i < `HDC_DIM; i++) begin
                vote_q[i] <= '0;
            end
        end else if (accept) begin
            for (int i = 0; i < `HDC_DIM; i++) begin
                vote_q[i] <= vote_q[i] + cnt_t'(S_AXIS_TDATA[i]);
            end
        end
    end

    // majority compares 2c against n and a tie takes tie_vec
    always_comb begin
        for (int i = 0; i < `HDC_DIM; i++) begin
            if ({vote_q[i], 1'b0} > {1'b0, beats_q}) begin
                res_data[i] = 1'b1;
            end else if ({vote_q[i], 1'b0} < {1'b0, beats_q}) begin
                res_data[i] = 1'b0;
            end else begin
                res_data[i] = tie_vec[i];
            end
        end
    end

endmodule

`default_nettype wire

/* src/hdc_bundler.sv */
`timescale 1ns/10ps
`default_nettype none

module hdc_bundler (
    input  wire logic         AXIS_ACLK,
    input  wire logic         S_AXI_ARESETN,
    // AXI-Lite control
    input  wire logic [11:0]  S_AXI_AWADDR,
    input  wire logic         S_AXI_AWVALID,
    output logic              S_AXI_AWREADY,
    input  wire logic [31:0]  S_AXI_WDATA,
    input  wire logic [3:0]   S_AXI_WSTRB,
    input  wire logic         S_AXI_WVALID,
    output logic              S_AXI_WREADY,
    output logic [1:0]        S_AXI_BRESP,
    output logic              S_AXI_BVALID,
    input  wire logic         S_AXI_BREADY,
    input  wire logic [11:0]  S_AXI_ARADDR,
    input  wire logic         S_AXI_ARVALID,
    output logic              S_AXI_ARREADY,
    output logic [31:0]       S_AXI_RDATA,
    output logic [1:0]        S_AXI_RRESP,
    output logic              S_AXI_RVALID,
    input  wire logic         S_AXI_RREADY,
    // input stream
    input  wire hdc_pkg::hv_t S_AXIS_TDATA,
    input  wire logic         S_AXIS_TVALID,
    input  wire logic         S_AXIS_TLAST,
    output logic              S_AXIS_TREADY,
    // output stream
    output hdc_pkg::hv_t      M_AXIS_TDATA,
    output logic              M_AXIS_TVALID,
    output logic              M_AXIS_TLAST,
    input  wire logic         M_AXIS_TREADY
);

    import hdc_pkg::*;

    ctrl_t ctrl;
    hv_t   tie_vec;
    logic  gen_done;
    hv_t   res_data;
    logic  res_valid;
    logic  res_ready;

    // ============================================================
    // input side
    // ============================================================

    axil_regs i_axil_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .gen_done      (gen_done),
        .ctrl          (ctrl)
    );

    // ============================================================
    // processing
    // ============================================================

    item_vector_gen i_item_vector_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (ctrl),
        .tie_vec       (tie_vec),
        .gen_done      (gen_done)
    );

    bundle_accum i_bundle_accum (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (ctrl),
        .tie_vec       (tie_vec),
        .S_AXIS_TDATA  (S_AXIS_TDATA),
        .S_AXIS_TVALID (S_AXIS_TVALID),
        .S_AXIS_TLAST  (S_AXIS_TLAST),
        .S_AXIS_TREADY (S_AXIS_TREADY),
        .res_data      (res_data),
        .res_valid     (res_valid),
        .res_ready     (res_ready)
    );

    // output side
    result_buffer i_result_buffer (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .run           (ctrl.run),
        .res_data      (res_data),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .M_AXIS_TDATA  (M_AXIS_TDATA),
        .M_AXIS_TVALID (M_AXIS_TVALID),
        .M_AXIS_TLAST  (M_AXIS_TLAST),
        .M_AXIS_TREADY (M_AXIS_TREADY)
    );

endmodule

`default_nettype wire

/* src/hdc_pkg.sv */
`include "hdc_settings.svh"

package hdc_pkg;

    // ============================================================
    // data types
    // ============================================================

    // one full hypervector
    typedef logic [`HDC_DIM-1:0] hv_t;

    // per-bit vote count or beat count
    typedef logic [`HDC_CNT_W-1:0] cnt_t;

    // item index for tie-break selection
    typedef logic [`HDC_IDX_W-1:0] idx_t;

    // ============================================================
    // control word from the register block
    // ============================================================

    // run enables bundling and gen starts item generation
    typedef struct packed {
        logic run;
        logic gen;
        idx_t item_sel;
    } ctrl_t;

endpackage

/* src/hdc_settings.svh */
`ifndef HDC_SETTINGS_SVH
`define HDC_SETTINGS_SVH

// ============================================================
// hypervector geometry
// ============================================================

`define HDC_DIM         256
`define HDC_WORD        32
// generator words per hypervector
`define HDC_WORDS       8

// counter width allows at most 255 beats per bundle
`define HDC_CNT_W       8
`define HDC_IDX_W       16

// ============================================================
// register map and generator seed
// ============================================================

`define HDC_REG_CTRL    12'h000
`define HDC_REG_ITEM    12'h004

`define HDC_SEED        32'd2463534242

`endif

/* src/item_vector_gen.sv */
`timescale 1ns/10ps
`default_nettype none
`include "hdc_settings.svh"

module item_vector_gen (
    input  wire logic           AXIS_ACLK,
    input  wire logic           S_AXI_ARESETN,
    input  wire hdc_pkg::ctrl_t ctrl,
    output hdc_pkg::hv_t        tie_vec,
    output logic                gen_done
);

    import hdc_pkg::*;

    localparam int WCNT_W = $clog2(`HDC_WORDS);

    logic [`HDC_WORD-1:0] rng_q;
    logic [`HDC_WORD-1:0] rng_next;
    logic [WCNT_W-1:0]    wcnt;
    idx_t                 vcnt;
    hv_t                  asm_q;
    hv_t                  full_vec;
    logic                 vec_last;

    // xorshift32 with shifts 13, 17 and 5
    function automatic logic [`HDC_WORD-1:0] xorshift32(input logic [`HDC_WORD-1:0] s);
        logic [`HDC_WORD-1:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign rng_next = xorshift32(rng_q);
    assign vec_last = (wcnt == WCNT_W'(`HDC_WORDS - 1));

    // completed vector including the word produced this cycle
    always_comb begin
        full_vec = asm_q;
        full_vec[`HDC_DIM-1 -: `HDC_WORD] = rng_next;
    end

    // ============================================================
    // generator state and counters
    // ============================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !ctrl.gen) begin
            rng_q <= `HDC_SEED;
            wcnt  <= '0;
            vcnt  <= '0;
        end else begin
            rng_q <= rng_next;
            wcnt  <= vec_last ? '0 : wcnt + 1'b1;
            if (vec_last) begin
                vcnt <= vcnt + 1'b1;
            end
        end
    end

    // word j goes to bits 32j upward
    always_ff @(posedge AXIS_ACLK) begin
        if (ctrl.gen) begin
            asm_q[wcnt*`HDC_WORD +: `HDC_WORD] <= rng_next;
        end
    end

    // capture the selected item and pulse done
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            tie_vec  <= '0;
            gen_done <= 1'b0;
        end else begin
            gen_done <= 1'b0;
            if (ctrl.gen && vec_last && (vcnt == ctrl.item_sel)) begin
                tie_vec  <= full_vec;
                gen_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/result_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module result_buffer (
    input  wire logic         AXIS_ACLK,
    input  wire logic         S_AXI_ARESETN,
    input  wire logic         run,
    input  wire hdc_pkg::hv_t res_data,
    input  wire logic         res_valid,
    output logic              res_ready,
    output hdc_pkg::hv_t      M_AXIS_TDATA,
    output logic              M_AXIS_TVALID,
    output logic              M_AXIS_TLAST,
    input  wire logic         M_AXIS_TREADY
);

    import hdc_pkg::*;

    hv_t        mem_q [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // ============================================================
    // occupancy driven handshakes
    // ============================================================

    assign res_ready     = (count != 2'd2);
    assign M_AXIS_TVALID = (count != 2'd0);
    assign M_AXIS_TDATA  = mem_q[rd_ptr];
    // every result is a single-beat packet
    assign M_AXIS_TLAST  = M_AXIS_TVALID;

    assign push = res_valid && res_ready;
    assign pop  = M_AXIS_TVALID && M_AXIS_TREADY;

    // flushed while run is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !run) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (push) begin
            mem_q[wr_ptr] <= res_data;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_hdc_bundler.sv */
`timescale 1ns/10ps
`include "hdc_settings.svh"

module tb_hdc_bundler;

    import hdc_pkg::*;

    localparam int CLK_NS     = 100;
    localparam int HS_LIMIT   = 64;
    localparam int POLL_LIMIT = 20;
    // about 8 cycles per register access and 6 per stream beat
    localparam int ACCESSES   = 20 + POLL_LIMIT;
    localparam int BEATS      = 20;
    localparam int BUDGET     = 8 * ACCESSES + 6 * BEATS + 200;

    localparam int F_AWREADY = 0;
    localparam int F_WREADY  = 1;
    localparam int F_BVALID  = 2;
    localparam int F_ARREADY = 3;
    localparam int F_RVALID  = 4;
    localparam int F_STREADY = 5;
    localparam int F_MTVALID = 6;

    logic        clk;
    logic        rstn;
    logic [11:0] awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    hv_t         s_tdata, m_tdata;
    logic        s_tvalid, s_tlast, s_tready;
    logic        m_tvalid, m_tlast, m_tready;

    integer      seed = 32'h300f;
    int          errors = 0;
    int          checks = 0;
    hv_t         sent [$];
    hv_t         tie_ref;

    hdc_bundler i_hdc_bundler (
        .AXIS_ACLK     (clk),
        .S_AXI_ARESETN (rstn),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (awready),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WSTRB   (wstrb),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (wready),
        .S_AXI_BRESP   (bresp),
        .S_AXI_BVALID  (bvalid),
        .S_AXI_BREADY  (bready),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready),
        .S_AXI_RDATA   (rdata),
        .S_AXI_RRESP   (rresp),
        .S_AXI_RVALID  (rvalid),
        .S_AXI_RREADY  (rready),
        .S_AXIS_TDATA  (s_tdata),
        .S_AXIS_TVALID (s_tvalid),
        .S_AXIS_TLAST  (s_tlast),
        .S_AXIS_TREADY (s_tready),
        .M_AXIS_TDATA  (m_tdata),
        .M_AXIS_TVALID (m_tvalid),
        .M_AXIS_TLAST  (m_tlast),
        .M_AXIS_TREADY (m_tready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(BUDGET * CLK_NS);
        $display("watchdog expired at %0t, tests did not complete", $time);
        $display("*** FAILED ***");
        $finish;
    end

    // ============================================================
    // reference models
    // ============================================================

    // vector idx is made of outputs idx*8 .. idx*8+7 of the xorshift stream
    function automatic hv_t xorshift_item(input int idx);
        logic [31:0] s;
        hv_t         v;
        int          j;
        s = `HDC_SEED;
        v = '0;
        for (int k = 0; k < (idx + 1) * `HDC_WORDS; k++) begin
            s = s ^ (s << 13);
            s = s ^ (s >> 17);
            s = s ^ (s << 5);
            j = k - idx * `HDC_WORDS;
            if (j >= 0) begin
                v[j*`HDC_WORD +: `HDC_WORD] = s;
            end
        end
        return v;
    endfunction

    function automatic hv_t majority_of(input hv_t tie);
        hv_t r;
        int  c;
        int  n;
        n = sent.size();
        for (int i = 0; i < `HDC_DIM; i++) begin
            c = 0;
            foreach (sent[b]) begin
                c += int'(sent[b][i]);
            end
            if (2 * c > n) begin
                r[i] = 1'b1;
            end else if (2 * c < n) begin
                r[i] = 1'b0;
            end else begin
                r[i] = tie[i];
            end
        end
        return r;
    endfunction

    function automatic hv_t rand_hv();
        hv_t v;
        for (int w = 0; w < `HDC_WORDS; w++) begin
            v[w*`HDC_WORD +: `HDC_WORD] = $random(seed);
        end
        return v;
    endfunction

    // ============================================================
    // bus helpers
    // ============================================================

    task automatic check(input string name, input hv_t exp, input hv_t act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic logic flag(input int which);
        case (which)
            F_AWREADY: flag = awready;
            F_WREADY:  flag = wready;
            F_BVALID:  flag = bvalid;
            F_ARREADY: flag = arready;
            F_RVALID:  flag = rvalid;
            F_STREADY: flag = s_tready;
            F_MTVALID: flag = m_tvalid;
            default:   flag = 1'b0;
        endcase
    endfunction

    // sampled on the falling edge so the transfer completes on the next rising one
    task automatic wait_flag(input int which, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!flag(which) && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!flag(which)) begin
            $display("timeout at %0t: %s never went high in %0d cycles", $time, what, n);
            errors++;
        end
    endtask

    // order 0 address and data together, 1 address first, 2 data first
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data, input int order);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hf;
        awvalid <= (order != 2);
        wvalid  <= (order != 1);
        wait_flag(order == 2 ? F_WREADY : F_AWREADY, "first write channel ready");
        @(posedge clk);
        awvalid <= (order == 2);
        wvalid  <= (order == 1);
        if (order != 0) begin
            wait_flag(order == 1 ? F_WREADY : F_AWREADY, "second write channel ready");
            @(posedge clk);
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end
        bready <= 1'b1;
        wait_flag(F_BVALID, "S_AXI_BVALID");
        check("S_AXI_BRESP", '0, hv_t'(bresp));
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        wait_flag(F_ARREADY, "S_AXI_ARREADY");
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        wait_flag(F_RVALID, "S_AXI_RVALID");
        data = rdata;
        check("S_AXI_RRESP", '0, hv_t'(rresp));
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp,
                               input string name);
        logic [31:0] rd;
        axil_read(addr, rd);
        check(name, hv_t'(exp), hv_t'(rd));
    endtask

    task automatic send_beat(input hv_t data, input logic last);
        @(posedge clk);
        s_tdata  <= data;
        s_tlast  <= last;
        s_tvalid <= 1'b1;
        wait_flag(F_STREADY, "S_AXIS_TREADY");
        @(posedge clk);
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
    endtask

    task automatic send_bundle();
        foreach (sent[b]) begin
            send_beat(sent[b], b == sent.size() - 1);
        end
    endtask

    task automatic recv_beat(input hv_t exp, input string name);
        @(posedge clk);
        m_tready <= 1'b1;
        wait_flag(F_MTVALID, "M_AXIS_TVALID");
        check(name, exp, m_tdata);
        check("M_AXIS_TLAST", hv_t'(1), hv_t'(m_tlast));
        @(posedge clk);
        m_tready <= 1'b0;
    endtask

    // ============================================================
    // directed tests
    // ============================================================

    task automatic exercise_registers();
        @(negedge clk);
        check("S_AXI_BVALID", '0, hv_t'(bvalid));
        check("S_AXI_RVALID", '0, hv_t'(rvalid));
        check("M_AXIS_TVALID", '0, hv_t'(m_tvalid));
        check("S_AXIS_TREADY", '0, hv_t'(s_tready));
        axil_write(`HDC_REG_ITEM, 32'hdead_1234, 0);
        read_expect(`HDC_REG_ITEM, 32'h0000_1234, "ITEM together");
        axil_write(`HDC_REG_ITEM, 32'h0000_00a5, 1);
        read_expect(`HDC_REG_ITEM, 32'h0000_00a5, "ITEM address first");
        axil_write(`HDC_REG_ITEM, 32'h0000_5a00, 2);
        read_expect(`HDC_REG_ITEM, 32'h0000_5a00, "ITEM data first");
        axil_write(`HDC_REG_CTRL, 32'h2, 1);
        read_expect(`HDC_REG_CTRL, 32'h2, "CTRL run");
        axil_write(`HDC_REG_CTRL, 32'h0, 2);
        read_expect(`HDC_REG_CTRL, 32'h0, "CTRL cleared");
        // unknown offsets
        axil_write(12'h00c, 32'hffff_ffff, 0);
        read_expect(12'h00c, 32'h0, "unknown offset");
        read_expect(`HDC_REG_ITEM, 32'h0000_5a00, "ITEM after stray write");
        read_expect(`HDC_REG_CTRL, 32'h0, "CTRL after stray write");
    endtask

    task automatic run_generation();
        logic [31:0] rd;
        int          polls;
        axil_write(`HDC_REG_ITEM, 32'd3, 0);
        axil_write(`HDC_REG_CTRL, 32'h1, 0);
        polls = 0;
        rd    = 32'h1;
        while (rd[0] && polls < POLL_LIMIT) begin
            axil_read(`HDC_REG_CTRL, rd);
            polls++;
        end
        if (rd[0]) begin
            $display("generation never finished, gen bit set after %0d polls", polls);
            errors++;
        end
        tie_ref = xorshift_item(3);
    endtask

    task automatic single_vector();
        hv_t v;
        axil_write(`HDC_REG_CTRL, 32'h2, 0);
        v = rand_hv();
        send_beat(v, 1'b1);
        recv_beat(v, "M_AXIS_TDATA single");
    endtask

    task automatic odd_majority();
        sent.delete();
        repeat (5) sent.push_back(rand_hv());
        send_bundle();
        recv_beat(majority_of(tie_ref), "M_AXIS_TDATA odd bundle");
    endtask

    // a and ~a cancel, so a bit ties wherever the last two differ
    task automatic even_ties();
        hv_t a;
        a = rand_hv();
        sent.delete();
        sent.push_back(a);
        sent.push_back(~a);
        sent.push_back(rand_hv());
        sent.push_back(rand_hv());
        send_bundle();
        recv_beat(majority_of(tie_ref), "M_AXIS_TDATA even bundle");
    endtask

    task automatic output_stall();
        hv_t v [3];
        for (int k = 0; k < 3; k++) begin
            v[k] = rand_hv();
            send_beat(v[k], 1'b1);
        end
        // two results buffered and the third held in the accumulator
        repeat (4) begin
            @(negedge clk);
            check("S_AXIS_TREADY", '0, hv_t'(s_tready));
        end
        for (int k = 0; k < 3; k++) begin
            recv_beat(v[k], "M_AXIS_TDATA after stall");
        end
    endtask

    initial begin
        rstn     <= 1'b0;
        awaddr   <= '0;
        awvalid  <= 1'b0;
        wdata    <= '0;
        wstrb    <= '0;
        wvalid   <= 1'b0;
        bready   <= 1'b0;
        araddr   <= '0;
        arvalid  <= 1'b0;
        rready   <= 1'b0;
        s_tdata  <= '0;
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
        m_tready <= 1'b0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        exercise_registers();
        run_generation();
        single_vector();
        odd_majority();
        even_ties();
        output_stall();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
